// ==== filelist.f ====
src/cpuPkg.sv
src/registerFile.sv
src/specialRegisters.sv
src/aluUnit.sv
src/busMux.sv
src/dataPath.sv
bench/dataPath_assert.sv
bench/dataPathTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dataPathTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SOURCES := $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/dataPathTb.sv ====
module dataPathTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int Period = 20;
	localparam int DriveDelay = 2;
	localparam cpuPkg::aluOp_t LogicOps [6] = '{cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd,
		cpuPkg::OpOr, cpuPkg::OpNeg, cpuPkg::OpNot};
	localparam cpuPkg::aluOp_t ShiftOps [5] = '{cpuPkg::OpShr, cpuPkg::OpShra, cpuPkg::OpShl,
		cpuPkg::OpRor, cpuPkg::OpRol};

	logic Clock;
	logic rst;
	cpuPkg::busSources_t sources;
	cpuPkg::regLoads_t loads;
	logic read;
	logic incPc;
	cpuPkg::aluOp_t aluOp;
	cpuPkg::word_t memDataIn;
	cpuPkg::word_t bus;
	cpuPkg::word_t mar;
	cpuPkg::word_t ir;

	cpuPkg::word_t lfsrState = 32'h39c4_475e;
	logic checkArmed = 1'b0;
	string checkName;
	int checkCount = 0;
	int errorCount = 0;

	// register contents as the transfer rules predict them.
	cpuPkg::word_t shadowReg [16];
	cpuPkg::word_t shadowPc;
	cpuPkg::word_t shadowMdr;
	cpuPkg::word_t shadowY;
	cpuPkg::word_t shadowHi;
	cpuPkg::word_t shadowLo;
	cpuPkg::word_t shadowMar;
	cpuPkg::word_t shadowIr;
	cpuPkg::dword_t shadowZ;

	dataPath #(.RegCount(16)) DUT (.*);

	initial begin
		Clock = 1'b0;
		forever begin
			#(Period / 2) Clock = ~Clock;
		end
	end

	// taps 32, 22, 2, 1.
	function automatic logic lfsrStep();
		logic feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	function automatic cpuPkg::word_t randomBits(input int count);
		cpuPkg::word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrStep()};
		end
		return value;
	endfunction

	// y is the first operand, bus the second; unary ops take the bus.
	function automatic cpuPkg::dword_t refAlu(input cpuPkg::aluOp_t op, input cpuPkg::word_t a,
		input cpuPkg::word_t b);
		int n;
		cpuPkg::word_t ones;
		n = b[4:0];
		ones = '1;
		case (op)
			cpuPkg::OpAdd: return {32'd0, a + b};
			cpuPkg::OpSub: return {32'd0, a - b};
			cpuPkg::OpAnd: return {32'd0, a & b};
			cpuPkg::OpOr: return {32'd0, a | b};
			cpuPkg::OpShr: return {32'd0, a >> n};
			cpuPkg::OpShra: return {32'd0, (a >> n) | (a[31] ? ~(ones >> n) : 32'd0)};
			cpuPkg::OpShl: return {32'd0, a << n};
			cpuPkg::OpRor: return {32'd0, (a >> n) | (a << (32 - n))};
			cpuPkg::OpRol: return {32'd0, (a << n) | (a >> (32 - n))};
			cpuPkg::OpMul: return cpuPkg::dword_t'(longint'($signed(a)) * longint'($signed(b)));
			cpuPkg::OpNeg: return {32'd0, 32'd0 - b};
			cpuPkg::OpNot: return {32'd0, ~b};
			default: return '0;
		endcase
	endfunction

	function automatic cpuPkg::word_t sourceValue(input cpuPkg::busSources_t src);
		for (int i = 0; i < 16; i++) begin
			if (src.regOut[i]) return shadowReg[i];
		end
		if (src.pcOut) return shadowPc;
		if (src.mdrOut) return shadowMdr;
		if (src.hiOut) return shadowHi;
		if (src.loOut) return shadowLo;
		if (src.zHighOut) return shadowZ[63:32];
		if (src.zLowOut) return shadowZ[31:0];
		return '0;
	endfunction

	function automatic cpuPkg::busSources_t regSrc(input int idx);
		cpuPkg::busSources_t src;
		src = '0;
		src.regOut[idx] = 1'b1;
		return src;
	endfunction

	function automatic cpuPkg::regLoads_t regLd(input int idx);
		cpuPkg::regLoads_t ld;
		ld = '0;
		ld.regIn[idx] = 1'b1;
		return ld;
	endfunction

	function automatic cpuPkg::busSources_t specialSrc(input string which);
		cpuPkg::busSources_t src;
		src = '0;
		case (which)
			"pc": src.pcOut = 1'b1;
			"mdr": src.mdrOut = 1'b1;
			"hi": src.hiOut = 1'b1;
			"lo": src.loOut = 1'b1;
			"zHigh": src.zHighOut = 1'b1;
			"zLow": src.zLowOut = 1'b1;
			default: src = '0;
		endcase
		return src;
	endfunction

	task automatic checkValue(input string name, input cpuPkg::word_t expected,
		input cpuPkg::word_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	// each edge must come within two periods.
	task automatic waitCycles(input int count);
		logic edgeSeen;
		edgeSeen = 1'b1;
		for (int e = 0; e < count && edgeSeen; e++) begin
			edgeSeen = 1'b0;
			fork
				begin
					@(posedge Clock);
					edgeSeen = 1'b1;
				end
				#(2 * Period);
			join_any
			disable fork;
		end
		if (edgeSeen) begin
			#DriveDelay;
		end else begin
			$display("timeout: no rising clock edge within two periods");
			$display("Result: FAILED");
			$finish;
		end
	endtask

	task automatic clearShadow();
		foreach (shadowReg[i]) begin
			shadowReg[i] = '0;
		end
		shadowPc = '0;
		shadowMdr = '0;
		shadowY = '0;
		shadowHi = '0;
		shadowLo = '0;
		shadowMar = '0;
		shadowIr = '0;
		shadowZ = '0;
	endtask

	// one clock of the strobes now driven, then the shadow follows the edge.
	task automatic clockTransfer();
		cpuPkg::word_t busValue;
		cpuPkg::dword_t zNext;
		busValue = sourceValue(sources);
		zNext = refAlu(aluOp, shadowY, busValue);
		waitCycles(1);
		for (int i = 0; i < 16; i++) begin
			if (loads.regIn[i]) shadowReg[i] = busValue;
		end
		if (loads.pcIn) shadowPc = busValue;
		else if (incPc) shadowPc = shadowPc + 32'd1;
		if (loads.mdrIn) shadowMdr = read ? memDataIn : busValue;
		if (loads.irIn) shadowIr = busValue;
		if (loads.marIn) shadowMar = busValue;
		if (loads.yIn) shadowY = busValue;
		if (loads.hiIn) shadowHi = busValue;
		if (loads.loIn) shadowLo = busValue;
		if (loads.zIn) shadowZ = zNext;
		sources = '0;
		loads = '0;
		read = 1'b0;
		incPc = 1'b0;
	endtask

	task automatic moveToReg(input cpuPkg::busSources_t src, input cpuPkg::regLoads_t ld);
		sources = src;
		loads = ld;
		clockTransfer();
	endtask

	task automatic memToMdr(input cpuPkg::word_t word);
		memDataIn = word;
		read = 1'b1;
		loads.mdrIn = 1'b1;
		clockTransfer();
	endtask

	task automatic aluStep(input cpuPkg::aluOp_t op, input cpuPkg::busSources_t src);
		aluOp = op;
		sources = src;
		loads.zIn = 1'b1;
		clockTransfer();
	endtask

	task automatic readBus(input cpuPkg::busSources_t src, input string name);
		checkName = name;
		checkArmed = 1'b1;
		sources = src;
		clockTransfer();
		checkArmed = 1'b0;
	endtask

	task automatic readSpecial(input string which);
		readBus(specialSrc(which), which);
	endtask

	task automatic loadReg(input int idx, input cpuPkg::word_t word);
		memToMdr(word);
		moveToReg(specialSrc("mdr"), regLd(idx));
	endtask

	// bus is settled by the falling edge.
	always @(negedge Clock) begin
		if (checkArmed) begin
			checkValue(checkName, sourceValue(sources), bus);
		end
	end

	initial begin
		cpuPkg::regLoads_t yLoad;
		cpuPkg::regLoads_t ld;
		cpuPkg::word_t amount;
		yLoad = '0;
		yLoad.yIn = 1'b1;
		rst = 1'b1;
		sources = '0;
		loads = '0;
		read = 1'b0;
		incPc = 1'b0;
		aluOp = '0;
		memDataIn = '0;
		clearShadow();
		waitCycles(4);
		rst = 1'b0;

		// pc, mar and ir.
		readSpecial("pc");
		checkValue("mar", shadowMar, mar);
		checkValue("ir", shadowIr, ir);
		for (int k = 0; k < 5; k++) begin
			incPc = 1'b1;
			clockTransfer();
		end
		readSpecial("pc");
		ld = '0;
		ld.marIn = 1'b1;
		moveToReg(specialSrc("pc"), ld);
		checkValue("mar", shadowMar, mar);
		memToMdr(randomBits(32));
		ld = '0;
		ld.irIn = 1'b1;
		moveToReg(specialSrc("mdr"), ld);
		checkValue("ir", shadowIr, ir);

		for (int i = 0; i < 16; i++) begin
			loadReg(i, randomBits(32));
		end
		for (int i = 0; i < 16; i++) begin
			readBus(regSrc(i), $sformatf("R%0d", i));
		end

		foreach (LogicOps[k]) begin
			moveToReg(regSrc(randomBits(4)), yLoad);
			aluStep(LogicOps[k], regSrc(randomBits(4)));
			readSpecial("zLow");
			readSpecial("zHigh");
		end

		// amounts 0, 31, then a full random word.
		foreach (ShiftOps[k]) begin
			for (int j = 0; j < 3; j++) begin
				amount = (j == 0) ? 32'd0 : (j == 1) ? 32'd31 : randomBits(32);
				loadReg(3, randomBits(32));
				loadReg(7, amount);
				moveToReg(regSrc(3), yLoad);
				aluStep(ShiftOps[k], regSrc(7));
				readSpecial("zLow");
				moveToReg(specialSrc("zLow"), regLd(4));
				readBus(regSrc(4), "R4");
			end
		end
		loadReg(3, 32'h0000_007f);
		loadReg(7, 32'd1);
		moveToReg(regSrc(3), yLoad);
		aluStep(cpuPkg::OpRol, regSrc(7));
		moveToReg(specialSrc("zLow"), regLd(4));
		checkValue("rol reference R4", 32'h0000_00fe, shadowReg[4]);
		readBus(regSrc(4), "R4");

		for (int k = 0; k < 4; k++) begin
			loadReg(5, randomBits(32));
			loadReg(6, randomBits(32));
			moveToReg(regSrc(5), yLoad);
			aluStep(cpuPkg::OpMul, regSrc(6));
			ld = '0;
			ld.hiIn = 1'b1;
			moveToReg(specialSrc("zHigh"), ld);
			ld = '0;
			ld.loIn = 1'b1;
			moveToReg(specialSrc("zLow"), ld);
			readSpecial("hi");
			readSpecial("lo");
		end

		readBus('0, "idle bus");
		rst = 1'b1;
		waitCycles(1);
		clearShadow();
		rst = 1'b0;
		for (int i = 0; i < 16; i++) begin
			readBus(regSrc(i), $sformatf("R%0d", i));
		end
		readSpecial("pc");
		readSpecial("mdr");
		readSpecial("hi");
		readSpecial("lo");
		readSpecial("zHigh");
		readSpecial("zLow");
		checkValue("mar", shadowMar, mar);
		checkValue("ir", shadowIr, ir);
		// y reaches the bus only through the alu.
		aluStep(cpuPkg::OpOr, '0);
		readSpecial("zLow");

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/dataPath_assert.sv ====
module dataPath_assert (
	input logic Clock,
	input logic rst,
	input cpuPkg::busSources_t sources,
	input cpuPkg::regLoads_t loads,
	input logic incPc,
	input cpuPkg::word_t zHigh,
	input cpuPkg::word_t zLow
);

	timeunit 1ns;
	timeprecision 100ps;

	// one driver on the bus at a time.
	sourceOneHot: assert property (@(posedge Clock) disable iff (rst) $onehot0(sources))
		else $error("more than one bus source driven");

	pcConflict: assert property (@(posedge Clock) disable iff (rst) !(loads.pcIn && incPc))
		else $error("pcIn and incPc high together");

	// Z only changes on a zIn edge.
	zHold: assert property (@(posedge Clock) disable iff (rst)
		!loads.zIn |=> $stable({zHigh, zLow}))
		else $error("Z changed while zIn was low");

endmodule

bind dataPath dataPath_assert assertions (
	.Clock(Clock),
	.rst(rst),
	.sources(sources),
	.loads(loads),
	.incPc(incPc),
	.zHigh(zHigh),
	.zLow(zLow)
);

// ==== src/dataPath.sv ====
module dataPath #(
	parameter int RegCount = 16
) (
	input logic Clock,
	input logic rst,
	input cpuPkg::busSources_t sources,
	input cpuPkg::regLoads_t loads,
	input logic read,
	input logic incPc,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::word_t memDataIn,
	output cpuPkg::word_t bus,
	output cpuPkg::word_t mar,
	output cpuPkg::word_t ir
);

	cpuPkg::word_t regValues [RegCount];
	cpuPkg::word_t pc;
	cpuPkg::word_t mdr;
	cpuPkg::word_t y;
	cpuPkg::word_t hi;
	cpuPkg::word_t lo;
	cpuPkg::word_t zHigh;
	cpuPkg::word_t zLow;

	registerFile #(.RegCount(RegCount)) generalRegs (
		.Clock(Clock),
		.rst(rst),
		.loadMask(loads.regIn[RegCount-1:0]),
		.bus(bus),
		.regValues(regValues)
	);

	specialRegisters specialRegs (
		.Clock(Clock),
		.rst(rst),
		.loads(loads),
		.read(read),
		.incPc(incPc),
		.memDataIn(memDataIn),
		.bus(bus),
		.pc(pc),
		.mdr(mdr),
		.y(y),
		.hi(hi),
		.lo(lo),
		.mar(mar),
		.ir(ir)
	);

	// Y is the first operand, the bus the second.
	aluUnit alu (
		.Clock(Clock),
		.rst(rst),
		.zIn(loads.zIn),
		.aluOp(aluOp),
		.y(y),
		.bus(bus),
		.zHigh(zHigh),
		.zLow(zLow)
	);

	busMux #(.RegCount(RegCount)) sourceMux (
		.sources(sources),
		.regValues(regValues),
		.pc(pc),
		.mdr(mdr),
		.hi(hi),
		.lo(lo),
		.zHigh(zHigh),
		.zLow(zLow),
		.bus(bus)
	);

endmodule

// ==== src/busMux.sv ====
module busMux #(
	parameter int RegCount = 16
) (
	input cpuPkg::busSources_t sources,
	input cpuPkg::word_t regValues [RegCount],
	input cpuPkg::word_t pc,
	input cpuPkg::word_t mdr,
	input cpuPkg::word_t hi,
	input cpuPkg::word_t lo,
	input cpuPkg::word_t zHigh,
	input cpuPkg::word_t zLow,
	output cpuPkg::word_t bus
);

	// select codes, registers first, then the special sources.
	localparam int SelWidth = $clog2(RegCount + 7);
	localparam logic [SelWidth-1:0] SelPc = SelWidth'(RegCount);
	localparam logic [SelWidth-1:0] SelMdr = SelWidth'(RegCount + 1);
	localparam logic [SelWidth-1:0] SelHi = SelWidth'(RegCount + 2);
	localparam logic [SelWidth-1:0] SelLo = SelWidth'(RegCount + 3);
	localparam logic [SelWidth-1:0] SelZHigh = SelWidth'(RegCount + 4);
	localparam logic [SelWidth-1:0] SelZLow = SelWidth'(RegCount + 5);
	localparam logic [SelWidth-1:0] SelNone = SelWidth'(RegCount + 6);

	logic [SelWidth-1:0] sel;
	cpuPkg::regIndex_t regIdx;

	// later checks override earlier ones, so low registers win.
	always_comb begin
		sel = SelNone;
		if (sources.zLowOut) sel = SelZLow;
		if (sources.zHighOut) sel = SelZHigh;
		if (sources.loOut) sel = SelLo;
		if (sources.hiOut) sel = SelHi;
		if (sources.mdrOut) sel = SelMdr;
		if (sources.pcOut) sel = SelPc;
		for (int i = RegCount - 1; i >= 0; i--) begin
			if (sources.regOut[i]) sel = SelWidth'(i);
		end
	end

	assign regIdx = cpuPkg::regIndex_t'(sel);

	always_comb begin
		case (sel)
			SelPc: bus = pc;
			SelMdr: bus = mdr;
			SelHi: bus = hi;
			SelLo: bus = lo;
			SelZHigh: bus = zHigh;
			SelZLow: bus = zLow;
			SelNone: bus = '0;
			default: bus = regValues[regIdx];
		endcase
	end

endmodule

// ==== src/aluUnit.sv ====
module aluUnit (
	input logic Clock,
	input logic rst,
	input logic zIn,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::word_t y,
	input cpuPkg::word_t bus,
	output cpuPkg::word_t zHigh,
	output cpuPkg::word_t zLow
);

	logic [4:0] amount;
	logic signed [63:0] product;
	cpuPkg::dword_t rotRight;
	cpuPkg::dword_t rotLeft;
	cpuPkg::word_t lowResult;
	cpuPkg::dword_t result;
	cpuPkg::dword_t z;

	// shift amount from the low bus bits.
	assign amount = bus[4:0];
	assign product = $signed(y) * $signed(bus);

	// doubled word makes rotates plain shifts.
	assign rotRight = {y, y} >> amount;
	assign rotLeft = {y, y} << amount;

	always_comb begin
		case (aluOp)
			cpuPkg::OpAdd: lowResult = y + bus;
			cpuPkg::OpSub: lowResult = y - bus;
			cpuPkg::OpAnd: lowResult = y & bus;
			cpuPkg::OpOr: lowResult = y | bus;
			cpuPkg::OpShr: lowResult = y >> amount;
			cpuPkg::OpShra: lowResult = cpuPkg::word_t'($signed(y) >>> amount);
			cpuPkg::OpShl: lowResult = y << amount;
			cpuPkg::OpRor: lowResult = rotRight[31:0];
			cpuPkg::OpRol: lowResult = rotLeft[63:32];
			// unary ops act on the bus word.
			cpuPkg::OpNeg: lowResult = -bus;
			cpuPkg::OpNot: lowResult = ~bus;
			default: lowResult = '0;
		endcase
	end

	// only multiply fills the high half.
	assign result = (aluOp == cpuPkg::OpMul) ? cpuPkg::dword_t'(product) : {32'd0, lowResult};

	always_ff @(posedge Clock) begin
		if (rst) begin
			z <= '0;
		end else if (zIn) begin
			z <= result;
		end
	end

	assign zHigh = z[63:32];
	assign zLow = z[31:0];

endmodule

// ==== src/specialRegisters.sv ====
module specialRegisters (
	input logic Clock,
	input logic rst,
	input cpuPkg::regLoads_t loads,
	input logic read,
	input logic incPc,
	input cpuPkg::word_t memDataIn,
	input cpuPkg::word_t bus,
	output cpuPkg::word_t pc,
	output cpuPkg::word_t mdr,
	output cpuPkg::word_t y,
	output cpuPkg::word_t hi,
	output cpuPkg::word_t lo,
	output cpuPkg::word_t mar,
	output cpuPkg::word_t ir
);

	cpuPkg::word_t mdrNext;

	// memory word on a read cycle, bus otherwise.
	assign mdrNext = read ? memDataIn : bus;

	// a bus load takes priority over the increment.
	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= '0;
		end else if (loads.pcIn) begin
			pc <= bus;
		end else if (incPc) begin
			pc <= pc + 32'd1;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			mdr <= '0;
		end else if (loads.mdrIn) begin
			mdr <= mdrNext;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			ir <= '0;
			mar <= '0;
			y <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			if (loads.irIn) begin
				ir <= bus;
			end
			if (loads.marIn) begin
				mar <= bus;
			end
			if (loads.yIn) begin
				y <= bus;
			end
			if (loads.hiIn) begin
				hi <= bus;
			end
			if (loads.loIn) begin
				lo <= bus;
			end
		end
	end

endmodule

// ==== src/registerFile.sv ====
module registerFile #(
	parameter int RegCount = 16
) (
	input logic Clock,
	input logic rst,
	input logic [RegCount-1:0] loadMask,
	input cpuPkg::word_t bus,
	output cpuPkg::word_t regValues [RegCount]
);

	cpuPkg::word_t regs [RegCount];

	// each register loads from the bus on its own strobe.
	always_ff @(posedge Clock) begin
		for (int i = 0; i < RegCount; i++) begin
			if (rst) begin
				regs[i] <= '0;
			end else if (loadMask[i]) begin
				regs[i] <= bus;
			end
		end
	end

	// all contents go to the bus mux.
	always_comb begin
		for (int i = 0; i < RegCount; i++) begin
			regValues[i] = regs[i];
		end
	end

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [3:0] regIndex_t;
	typedef logic [4:0] aluOp_t;

	// alu operation codes.
	localparam aluOp_t OpAdd = 5'b00011;
	localparam aluOp_t OpSub = 5'b00100;
	localparam aluOp_t OpAnd = 5'b00101;
	localparam aluOp_t OpOr = 5'b00110;
	localparam aluOp_t OpRor = 5'b00111;
	localparam aluOp_t OpRol = 5'b01000;
	localparam aluOp_t OpShr = 5'b01001;
	localparam aluOp_t OpShra = 5'b01010;
	localparam aluOp_t OpShl = 5'b01011;
	localparam aluOp_t OpMul = 5'b01111;
	localparam aluOp_t OpNeg = 5'b10001;
	localparam aluOp_t OpNot = 5'b10010;

	// drive strobes, one source per cycle.
	typedef struct packed {
		logic [15:0] regOut;
		logic pcOut;
		logic mdrOut;
		logic hiOut;
		logic loOut;
		logic zHighOut;
		logic zLowOut;
	} busSources_t;

	// load strobes; zIn loads both Z halves.
	typedef struct packed {
		logic [15:0] regIn;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic yIn;
		logic hiIn;
		logic loIn;
		logic zIn;
	} regLoads_t;

endpackage
